//--- Makefile
# build and run with Verilator, pass decided from the log

sim:
	verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module battleship_tb -Mdir obj_dir -o battleship_sim
	./obj_dir/battleship_sim | tee sim.log
	grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

//--- common/battleship_params.svh
`ifndef BATTLESHIP_PARAMS_SVH
`define BATTLESHIP_PARAMS_SVH

// playfield geometry
`define GRID_CELLS 10
`define GRID_AREA  100 // GRID_CELLS squared
`define CELL_PIX   32
`define GRID_PIX   320 // GRID_CELLS times CELL_PIX

// 640x480 at 25 MHz pixel rate
`define H_VISIBLE 640
`define H_FRONT   16
`define H_SYNC    96
`define H_BACK    48
`define H_TOTAL   800

`define V_VISIBLE 480
`define V_FRONT   10
`define V_SYNC    2
`define V_BACK    33
`define V_TOTAL   525

// cell status codes, one per memory cell
`define CELL_STATUS_FREE          4'd0
`define CELL_STATUS_PLAYER_OCC    4'd1
`define CELL_STATUS_IA_OCC        4'd2
`define CELL_STATUS_PLAYER_IA_OCC 4'd3
`define CELL_STATUS_PLAYER_HITTED 4'd4
`define CELL_STATUS_IA_HITTED     4'd5
`define CELL_STATUS_MISS          4'd6

// what a click does
`define MODE_PLACE_PLAYER 2'd0
`define MODE_PLACE_IA     2'd1
`define MODE_FIRE_PLAYER  2'd2 // player shoots at opponent ships
`define MODE_FIRE_IA      2'd3 // opponent shoots at player ships

// ship lengths, used in turn
`define SHIP_SIZE_0 3'd2
`define SHIP_SIZE_1 3'd3
`define SHIP_SIZE_2 3'd3
`define SHIP_SIZE_3 3'd4
`define SHIP_SIZE_4 3'd4

// 4 bits per channel, r g b
`define COLOR_FREE          12'h00f // blue sea
`define COLOR_PLAYER_OCC    12'h0f0
`define COLOR_IA_OCC        12'h686 // grey green
`define COLOR_PLAYER_IA_OCC 12'h0ff
`define COLOR_PLAYER_HITTED 12'hf00
`define COLOR_IA_HITTED     12'hf80
`define COLOR_MISS          12'hfff
`define COLOR_BORDER        12'h888
`define COLOR_CURSOR        12'hff0
`define COLOR_BACKGROUND    12'h000

`endif

//--- common/grid_pkg.sv
`default_nettype none

`include "battleship_params.svh"

package grid_pkg;

	typedef logic [3:0] cell_status_t; // one of the CELL_STATUS codes
	typedef logic [3:0] cell_coord_t;  // column or row, 0 to 9
	typedef logic [6:0] cell_addr_t;   // row*10 + column
	typedef logic [1:0] game_mode_t;   // one of the MODE codes

	// linear cell index, row major
	function automatic cell_addr_t to_addr(input cell_coord_t col, input cell_coord_t row);
		return cell_addr_t'(row * `GRID_CELLS + col);
	endfunction

endpackage

`default_nettype wire

//--- common/video_pkg.sv
`default_nettype none

package video_pkg;

	typedef logic [9:0]  pixel_coord_t; // screen x or y, up to 799
	typedef logic [11:0] rgb_t;         // {r, g, b}

endpackage

`default_nettype wire

//--- dv/battleship_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "battleship_params.svh"

module battleship_tb;
	import grid_pkg::*;
	import video_pkg::*;

	localparam int CLK_NS      = 20;
	localparam int LINE_CLKS   = 2 * `H_TOTAL; // two clocks per pixel
	localparam int FRAME_CLKS  = LINE_CLKS * `V_TOTAL;
	localparam int WATCHDOG_NS = (4 * FRAME_CLKS + 20000) * CLK_NS;

	logic         clk_50m;
	logic         rst_n;
	cell_coord_t  cursor_x;
	cell_coord_t  cursor_y;
	logic         click;
	game_mode_t   mode;
	logic         vertical;
	cell_status_t led;
	logic [3:0]   vga_r;
	logic [3:0]   vga_g;
	logic [3:0]   vga_b;
	logic         vga_hsync;
	logic         vga_vsync;

	cell_status_t model [0:`GRID_AREA-1]; // expected grid memory
	int           next_ship [0:1];        // ship index of player and opponent
	int           checks;
	int           errors;

	battleship_top u_battleship_top (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.cursor_x(cursor_x), .cursor_y(cursor_y),
		.click(click), .mode(mode), .vertical(vertical),
		.led(led),
		.vga_r(vga_r), .vga_g(vga_g), .vga_b(vga_b),
		.vga_hsync(vga_hsync), .vga_vsync(vga_vsync)
	);

	initial begin
		clk_50m = 1'b0;
		forever #(CLK_NS / 2) clk_50m = ~clk_50m;
	end

	// runaway guard of a bit over four frames
	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns, tests did not finish", WATCHDOG_NS);
		$display("test failed");
		$finish;
	end

	function automatic int ship_length(input int idx);
		case (idx)
			1: return `SHIP_SIZE_1;
			2: return `SHIP_SIZE_2;
			3: return `SHIP_SIZE_3;
			4: return `SHIP_SIZE_4;
			default: return `SHIP_SIZE_0;
		endcase
	endfunction

	// what a click in mode m does to one cell
	function automatic cell_status_t apply_rule(input int m, input cell_status_t s);
		if (m == `MODE_PLACE_PLAYER) begin
			if (s == `CELL_STATUS_FREE) return `CELL_STATUS_PLAYER_OCC;
			if (s == `CELL_STATUS_IA_OCC) return `CELL_STATUS_PLAYER_IA_OCC;
		end else if (m == `MODE_PLACE_IA) begin
			if (s == `CELL_STATUS_FREE) return `CELL_STATUS_IA_OCC;
			if (s == `CELL_STATUS_PLAYER_OCC) return `CELL_STATUS_PLAYER_IA_OCC;
		end else if (m == `MODE_FIRE_PLAYER) begin
			if (s == `CELL_STATUS_IA_OCC || s == `CELL_STATUS_PLAYER_IA_OCC)
				return `CELL_STATUS_IA_HITTED;
			if (s == `CELL_STATUS_FREE) return `CELL_STATUS_MISS;
		end else begin
			if (s == `CELL_STATUS_PLAYER_OCC || s == `CELL_STATUS_PLAYER_IA_OCC)
				return `CELL_STATUS_PLAYER_HITTED;
			if (s == `CELL_STATUS_FREE) return `CELL_STATUS_MISS;
		end
		return s; // anything else stays
	endfunction

	function automatic rgb_t colour_of(input cell_status_t s);
		case (s)
			`CELL_STATUS_FREE:          return `COLOR_FREE;
			`CELL_STATUS_PLAYER_OCC:    return `COLOR_PLAYER_OCC;
			`CELL_STATUS_IA_OCC:        return `COLOR_IA_OCC;
			`CELL_STATUS_PLAYER_IA_OCC: return `COLOR_PLAYER_IA_OCC;
			`CELL_STATUS_PLAYER_HITTED: return `COLOR_PLAYER_HITTED;
			`CELL_STATUS_IA_HITTED:     return `COLOR_IA_HITTED;
			`CELL_STATUS_MISS:          return `COLOR_MISS;
			default:                    return `COLOR_BACKGROUND;
		endcase
	endfunction

	// screen colour the model predicts at pixel (x, y)
	function automatic rgb_t expect_pixel(input int x, input int y);
		if (x >= `GRID_PIX || y >= `GRID_PIX)
			return `COLOR_BACKGROUND;
		if (x % `CELL_PIX == 0 || y % `CELL_PIX == 0)
			return `COLOR_BORDER; // left and top line of each cell
		if (x / `CELL_PIX == int'(cursor_x) && y / `CELL_PIX == int'(cursor_y))
			return `COLOR_CURSOR;
		return colour_of(model[(y / `CELL_PIX) * `GRID_CELLS + x / `CELL_PIX]);
	endfunction

	// n rising edges then 1 ns to the drive point
	task automatic tick(input int n);
		repeat (n) @(posedge clk_50m);
		#1;
	endtask

	task automatic check_value(input string name, input int expected, input int actual);
		checks++;
		assert (actual == expected) else begin
			errors++;
			$display("FAIL %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
		end
	endtask

	task automatic wait_for_led(input cell_status_t expected, input int limit);
		int n;
		n = 0;
		while (led !== expected && n < limit) begin
			tick(1);
			n++;
		end
	endtask

	task automatic move_cursor(input string name, input int x, input int y);
		cell_status_t expected;
		expected = model[y * `GRID_CELLS + x];
		tick(1);
		cursor_x = cell_coord_t'(x);
		cursor_y = cell_coord_t'(y);
		tick(2); // a read of the old cell may still be in flight
		wait_for_led(expected, 32);
		// an early match may be the old cell so it has to outlast a refresh of the new one
		for (int n = 0; n < 8 && led === expected; n++)
			tick(1);
		check_value(name, expected, led);
	endtask

	// click at (x, y) in mode m while the model follows the same walk
	task automatic issue_command(input string name, input int x, input int y,
		input int m, input logic vert);
		int           len;
		int           side;
		int           cx;
		int           cy;
		int           addr;
		cell_status_t old_status;
		addr = y * `GRID_CELLS + x;
		move_cursor({name, " before"}, x, y);
		old_status = model[addr];
		len = 1; // a shot hits one cell
		if (m == `MODE_PLACE_PLAYER || m == `MODE_PLACE_IA) begin
			side = m % 2;
			len = ship_length(next_ship[side]);
			next_ship[side] = (next_ship[side] + 1) % 5;
		end
		for (int k = 0; k < len; k++) begin
			cx = vert ? x : x + k;
			cy = vert ? y + k : y;
			if (cx < `GRID_CELLS && cy < `GRID_CELLS) // clipped at the edge
				model[cy * `GRID_CELLS + cx] = apply_rule(m, model[cy * `GRID_CELLS + cx]);
		end
		mode     = game_mode_t'(m);
		vertical = vert;
		click    = 1'b1;
		tick(1);
		click = 1'b0;
		if (model[addr] != old_status)
			wait_for_led(model[addr], 400); // led moves once the command is done
		else
			tick(64); // no write so only a short read
		check_value(name, model[addr], led);
	endtask

	task automatic reset_check();
		tick(2);
		check_value("reset_check hsync in reset", 1, vga_hsync);
		check_value("reset_check vsync in reset", 1, vga_vsync);
		check_value("reset_check rgb in reset", 0, {vga_r, vga_g, vga_b});
		check_value("reset_check led in reset", `CELL_STATUS_FREE, led);
		tick(1);
		rst_n = 1'b1; // released after three cycles
		tick(1);
		check_value("reset_check hsync after", 1, vga_hsync);
		check_value("reset_check vsync after", 1, vga_vsync);
		check_value("reset_check rgb after", 0, {vga_r, vga_g, vga_b});
		check_value("reset_check led after", `CELL_STATUS_FREE, led);
	endtask

	task automatic place_ships();
		issue_command("place_ships player h2", 1, 1, `MODE_PLACE_PLAYER, 1'b0);
		issue_command("place_ships player v3", 8, 0, `MODE_PLACE_PLAYER, 1'b1);
		issue_command("place_ships opp h2", 2, 1, `MODE_PLACE_IA, 1'b0); // overlaps (2,1)
		issue_command("place_ships opp h3 clip", 8, 0, `MODE_PLACE_IA, 1'b0);
		issue_command("place_ships opp v3", 5, 7, `MODE_PLACE_IA, 1'b1); // ends on row 9
		for (int r = 0; r < `GRID_CELLS; r++)
			for (int c = 0; c < `GRID_CELLS; c++)
				move_cursor($sformatf("place_ships cell %0d,%0d", c, r), c, r);
	endtask

	task automatic fire_shots();
		issue_command("fire_shots player hit", 3, 1, `MODE_FIRE_PLAYER, 1'b0);
		issue_command("fire_shots player hit shared", 2, 1, `MODE_FIRE_PLAYER, 1'b0);
		issue_command("fire_shots player miss", 0, 9, `MODE_FIRE_PLAYER, 1'b0);
		issue_command("fire_shots player again", 3, 1, `MODE_FIRE_PLAYER, 1'b0);
		issue_command("fire_shots opp hit", 1, 1, `MODE_FIRE_IA, 1'b0);
		issue_command("fire_shots opp hit v", 8, 1, `MODE_FIRE_IA, 1'b0);
		issue_command("fire_shots opp hit shared", 8, 0, `MODE_FIRE_IA, 1'b0);
		issue_command("fire_shots opp miss", 4, 4, `MODE_FIRE_IA, 1'b0);
		issue_command("fire_shots opp again", 1, 1, `MODE_FIRE_IA, 1'b0);
		issue_command("fire_shots opp on miss", 0, 9, `MODE_FIRE_IA, 1'b0);
	endtask

	task automatic sync_timing();
		time t0;
		time t1;
		time t2;
		@(negedge vga_hsync);
		t0 = $time;
		@(posedge vga_hsync);
		t1 = $time;
		@(negedge vga_hsync);
		t2 = $time;
		check_value("sync_timing hsync low", 2 * `H_SYNC, int'((t1 - t0) / CLK_NS));
		check_value("sync_timing hsync period", LINE_CLKS, int'((t2 - t0) / CLK_NS));
		@(negedge vga_vsync);
		t0 = $time;
		@(posedge vga_vsync);
		t1 = $time;
		@(negedge vga_vsync);
		t2 = $time;
		check_value("sync_timing vsync low", `V_SYNC * LINE_CLKS, int'((t1 - t0) / CLK_NS));
		check_value("sync_timing vsync period", FRAME_CLKS, int'((t2 - t0) / CLK_NS));
	endtask

	// samples sorted by scan order with y first
	task automatic pixel_colours();
		int  xs [0:13] = '{272, 304, 400, 32, 48, 80, 112, 272, 240, 144, 208, 176, 16, 100};
		int  ys [0:13] = '{16, 16, 16, 48, 48, 48, 48, 48, 112, 144, 208, 240, 304, 400};
		time t_rise;
		time t_at;
		tick(1);
		cursor_x = cell_coord_t'(6);
		cursor_y = cell_coord_t'(6);
		@(posedge vga_vsync);
		t_rise = $time;
		for (int i = 0; i < 14; i++) begin
			t_at = t_rise + time'(2 * (`H_TOTAL * (`V_BACK + ys[i]) + xs[i]) * CLK_NS)
				+ time'(CLK_NS / 2); // middle of the first of two clocks
			#(t_at - $time);
			check_value($sformatf("pixel_colours %0d,%0d", xs[i], ys[i]),
				expect_pixel(xs[i], ys[i]), {vga_r, vga_g, vga_b});
		end
	endtask

	initial begin
		rst_n    = 1'b0;
		cursor_x = '0;
		cursor_y = '0;
		click    = 1'b0;
		mode     = `MODE_PLACE_PLAYER;
		vertical = 1'b0;
		checks   = 0;
		errors   = 0;
		next_ship[0] = 0;
		next_ship[1] = 0;
		for (int i = 0; i < `GRID_AREA; i++)
			model[i] = `CELL_STATUS_FREE; // open sea after reset
		reset_check();
		place_ships();
		fire_shots();
		sync_timing();
		pixel_colours();
		$display("%0d checks run, %0d errors", checks, errors);
		if (errors == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- grid/grid_engine.sv
`timescale 1ns/100ps
`default_nettype none

`include "battleship_params.svh"

module grid_engine (
	input  wire                         clk_50m,
	input  wire                         rst_n,
	input  wire grid_pkg::cell_coord_t  cursor_x,
	input  wire grid_pkg::cell_coord_t  cursor_y,
	input  wire                         click,
	input  wire grid_pkg::game_mode_t   mode,
	input  wire                         vertical,
	output logic                        wb_cyc,
	output logic                        wb_stb,
	output logic                        wb_we,
	output grid_pkg::cell_addr_t        wb_adr,
	output grid_pkg::cell_status_t      wb_dat_w,
	input  wire grid_pkg::cell_status_t wb_dat_r,
	input  wire                         wb_ack,
	output grid_pkg::cell_status_t      led
);
	import grid_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,  // cursor refresh reads
		ST_CELL,  // pick next cell of the ship or shot
		ST_READ,  // read old status
		ST_WRITE, // write new status back
		ST_NEXT   // step along the ship
	} state_t;

	state_t       state;
	cell_coord_t  cap_x; // cursor at click time
	cell_coord_t  cap_y;
	game_mode_t   cap_mode;
	logic         cap_vert;
	logic         click_pend; // click seen while a refresh read runs
	logic [2:0]   step;        // cell index along the ship
	logic [2:0]   ship_idx [0:1]; // next ship, one per placing side
	logic         placing;
	logic [2:0]   ship_len;
	cell_coord_t  cell_x;
	cell_coord_t  cell_y;
	logic         cell_ok;
	cell_status_t new_status;

	function automatic logic [2:0] ship_size(input logic [2:0] idx);
		case (idx)
			3'd1:    return `SHIP_SIZE_1;
			3'd2:    return `SHIP_SIZE_2;
			3'd3:    return `SHIP_SIZE_3;
			3'd4:    return `SHIP_SIZE_4;
			default: return `SHIP_SIZE_0;
		endcase
	endfunction

	// game rules, unknown combinations keep the old code
	function automatic cell_status_t next_status(input game_mode_t m, input cell_status_t s);
		cell_status_t r;
		r = s;
		case (m)
			`MODE_PLACE_PLAYER: begin
				if (s == `CELL_STATUS_FREE)
					r = `CELL_STATUS_PLAYER_OCC;
				else if (s == `CELL_STATUS_IA_OCC)
					r = `CELL_STATUS_PLAYER_IA_OCC;
			end
			`MODE_PLACE_IA: begin
				if (s == `CELL_STATUS_FREE)
					r = `CELL_STATUS_IA_OCC;
				else if (s == `CELL_STATUS_PLAYER_OCC)
					r = `CELL_STATUS_PLAYER_IA_OCC;
			end
			`MODE_FIRE_PLAYER: begin
				if (s == `CELL_STATUS_IA_OCC || s == `CELL_STATUS_PLAYER_IA_OCC)
					r = `CELL_STATUS_IA_HITTED;
				else if (s == `CELL_STATUS_FREE)
					r = `CELL_STATUS_MISS;
			end
			default: begin // opponent fires
				if (s == `CELL_STATUS_PLAYER_OCC || s == `CELL_STATUS_PLAYER_IA_OCC)
					r = `CELL_STATUS_PLAYER_HITTED;
				else if (s == `CELL_STATUS_FREE)
					r = `CELL_STATUS_MISS;
			end
		endcase
		return r;
	endfunction

	assign placing  = (cap_mode == `MODE_PLACE_PLAYER) || (cap_mode == `MODE_PLACE_IA);
	assign ship_len = placing ? ship_size(ship_idx[cap_mode[0]]) : 3'd1; // a shot is one cell
	assign cell_x   = cap_x + (cap_vert ? 4'd0 : {1'b0, step});
	assign cell_y   = cap_y + (cap_vert ? {1'b0, step} : 4'd0);
	assign cell_ok  = (cell_x < `GRID_CELLS) && (cell_y < `GRID_CELLS); // clip at the edge
	assign new_status = next_status(cap_mode, wb_dat_r);

	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			state       <= ST_IDLE;
			wb_cyc      <= 1'b0;
			wb_stb      <= 1'b0;
			wb_we       <= 1'b0;
			wb_adr      <= '0;
			wb_dat_w    <= `CELL_STATUS_FREE;
			led         <= `CELL_STATUS_FREE;
			cap_x       <= '0;
			cap_y       <= '0;
			cap_mode    <= `MODE_PLACE_PLAYER;
			cap_vert    <= 1'b0;
			click_pend  <= 1'b0;
			step        <= '0;
			ship_idx[0] <= '0;
			ship_idx[1] <= '0;
		end else begin
			case (state)
				ST_IDLE: begin
					if (click && !click_pend) begin // hold the command until the read ends
						cap_x      <= cursor_x;
						cap_y      <= cursor_y;
						cap_mode   <= mode;
						cap_vert   <= vertical;
						click_pend <= 1'b1;
					end
					if (!wb_cyc) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we  <= 1'b0;
						wb_adr <= to_addr(cursor_x, cursor_y);
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						led    <= wb_dat_r;
						if (click_pend || click) begin
							click_pend <= 1'b0;
							step       <= '0;
							state      <= ST_CELL;
						end
					end
				end
				ST_CELL: begin
					if (cell_ok) begin
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we  <= 1'b0;
						wb_adr <= to_addr(cell_x, cell_y);
						state  <= ST_READ;
					end else begin
						state <= ST_NEXT; // off the grid, skip
					end
				end
				ST_READ: begin
					if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						if (new_status != wb_dat_r) begin
							wb_dat_w <= new_status;
							state    <= ST_WRITE;
						end else begin
							state <= ST_NEXT; // nothing changes
						end
					end
				end
				ST_WRITE: begin
					if (!wb_cyc) begin // one idle cycle after the read ack
						wb_cyc <= 1'b1;
						wb_stb <= 1'b1;
						wb_we  <= 1'b1;
					end else if (wb_ack) begin
						wb_cyc <= 1'b0;
						wb_stb <= 1'b0;
						wb_we  <= 1'b0;
						state  <= ST_NEXT;
					end
				end
				default: begin // ST_NEXT
					if (step == ship_len - 3'd1) begin
						if (placing)
							ship_idx[cap_mode[0]] <= (ship_idx[cap_mode[0]] == 3'd4) ?
								3'd0 : ship_idx[cap_mode[0]] + 3'd1;
						state <= ST_IDLE;
					end else begin
						step  <= step + 3'd1;
						state <= ST_CELL;
					end
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- grid/grid_memory.sv
`timescale 1ns/100ps
`default_nettype none

`include "battleship_params.svh"

module grid_memory (
	input  wire                         clk_50m,
	input  wire                         rst_n,
	input  wire                         wb_cyc,
	input  wire                         wb_stb,
	input  wire                         wb_we,
	input  wire grid_pkg::cell_addr_t   wb_adr,
	input  wire grid_pkg::cell_status_t wb_dat_w,
	output grid_pkg::cell_status_t      wb_dat_r,
	output logic                        wb_ack,
	input  wire grid_pkg::cell_addr_t   rd_addr,
	output grid_pkg::cell_status_t      rd_data
);
	import grid_pkg::*;

	cell_status_t cells [0:`GRID_AREA-1];
	logic         req; // new request, not yet acked

	assign req = wb_cyc && wb_stb && !wb_ack;

	// cells start as open sea
	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			wb_ack <= 1'b0;
			for (int i = 0; i < `GRID_AREA; i++)
				cells[i] <= `CELL_STATUS_FREE;
		end else begin
			wb_ack <= req; // single cycle ack, one wait state
			if (req && wb_we)
				cells[wb_adr] <= wb_dat_w; // lands with the ack edge
		end
	end

	always_ff @(posedge clk_50m) begin
		if (req && !wb_we)
			wb_dat_r <= cells[wb_adr];
		rd_data <= cells[rd_addr]; // video port, free running
	end

endmodule

`default_nettype wire

//--- verilog/battleship_top.sv
`timescale 1ns/100ps
`default_nettype none

module battleship_top (
	input  wire                        clk_50m,
	input  wire                        rst_n,
	input  wire grid_pkg::cell_coord_t cursor_x,
	input  wire grid_pkg::cell_coord_t cursor_y,
	input  wire                        click,
	input  wire grid_pkg::game_mode_t  mode,
	input  wire                        vertical,
	output grid_pkg::cell_status_t     led,
	output logic [3:0]                 vga_r,
	output logic [3:0]                 vga_g,
	output logic [3:0]                 vga_b,
	output logic                       vga_hsync,
	output logic                       vga_vsync
);
	import grid_pkg::*;
	import video_pkg::*;

	// engine to memory bus
	logic         wb_cyc;
	logic         wb_stb;
	logic         wb_we;
	logic         wb_ack;
	cell_addr_t   wb_adr;
	cell_status_t wb_dat_w;
	cell_status_t wb_dat_r;

	// video side
	logic         pix_en;
	logic         active;
	pixel_coord_t h_count;
	pixel_coord_t v_count;
	cell_addr_t   rd_addr;
	cell_status_t rd_data;
	rgb_t         rgb;

	assign {vga_r, vga_g, vga_b} = rgb;

	grid_engine u_engine (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.cursor_x(cursor_x), .cursor_y(cursor_y),
		.click(click), .mode(mode), .vertical(vertical),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.led(led)
	);

	grid_memory u_memory (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
		.wb_dat_w(wb_dat_w), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
		.rd_addr(rd_addr), .rd_data(rd_data)
	);

	vga_sync u_sync (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.pix_en(pix_en), .h_count(h_count), .v_count(v_count), .active(active),
		.hsync(vga_hsync), .vsync(vga_vsync)
	);

	grid_renderer u_renderer (
		.clk_50m(clk_50m), .rst_n(rst_n),
		.pix_en(pix_en), .h_count(h_count), .v_count(v_count), .active(active),
		.cursor_x(cursor_x), .cursor_y(cursor_y), // highlight follows the live cursor
		.rd_addr(rd_addr), .rd_data(rd_data),
		.rgb(rgb)
	);

endmodule

`default_nettype wire

//--- video/grid_renderer.sv
`timescale 1ns/100ps
`default_nettype none

`include "battleship_params.svh"

module grid_renderer (
	input  wire                          clk_50m,
	input  wire                          rst_n,
	input  wire                          pix_en,
	input  wire video_pkg::pixel_coord_t h_count,
	input  wire video_pkg::pixel_coord_t v_count,
	input  wire                          active,
	input  wire grid_pkg::cell_coord_t   cursor_x,
	input  wire grid_pkg::cell_coord_t   cursor_y,
	output grid_pkg::cell_addr_t         rd_addr,
	input  wire grid_pkg::cell_status_t  rd_data,
	output video_pkg::rgb_t              rgb
);
	import grid_pkg::*;
	import video_pkg::*;

	logic        in_grid;
	cell_coord_t col;
	cell_coord_t row;
	logic        border;
	logic        on_cursor;

	function automatic rgb_t status_color(input cell_status_t s);
		case (s)
			`CELL_STATUS_FREE:          return `COLOR_FREE;
			`CELL_STATUS_PLAYER_OCC:    return `COLOR_PLAYER_OCC;
			`CELL_STATUS_IA_OCC:        return `COLOR_IA_OCC;
			`CELL_STATUS_PLAYER_IA_OCC: return `COLOR_PLAYER_IA_OCC;
			`CELL_STATUS_PLAYER_HITTED: return `COLOR_PLAYER_HITTED;
			`CELL_STATUS_IA_HITTED:     return `COLOR_IA_HITTED;
			`CELL_STATUS_MISS:          return `COLOR_MISS;
			default:                    return `COLOR_BACKGROUND;
		endcase
	endfunction

	assign in_grid   = (h_count < `GRID_PIX) && (v_count < `GRID_PIX);
	assign col       = h_count[8:5]; // 32 pixel cells
	assign row       = v_count[8:5];
	assign border    = (h_count[4:0] == 5'd0) || (v_count[4:0] == 5'd0); // left and top edge
	assign on_cursor = (col == cursor_x) && (row == cursor_y);
	assign rd_addr   = in_grid ? to_addr(col, row) : '0; // data back well before next tick

	// colour for the current counters, out on the next tick
	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			rgb <= `COLOR_BACKGROUND;
		end else if (pix_en) begin
			if (!active || !in_grid)
				rgb <= `COLOR_BACKGROUND;
			else if (border)
				rgb <= `COLOR_BORDER;
			else if (on_cursor)
				rgb <= `COLOR_CURSOR;
			else
				rgb <= status_color(rd_data);
		end
	end

endmodule

`default_nettype wire

//--- video/vga_sync.sv
`timescale 1ns/100ps
`default_nettype none

`include "battleship_params.svh"

module vga_sync (
	input  wire                      clk_50m,
	input  wire                      rst_n,
	output logic                     pix_en,
	output video_pkg::pixel_coord_t  h_count,
	output video_pkg::pixel_coord_t  v_count,
	output logic                     active,
	output logic                     hsync,
	output logic                     vsync
);
	import video_pkg::*;

	logic h_last; // last pixel of the line
	logic v_last; // last line of the frame
	logic h_pulse;
	logic v_pulse;

	assign h_last  = (h_count == pixel_coord_t'(`H_TOTAL - 1));
	assign v_last  = (v_count == pixel_coord_t'(`V_TOTAL - 1));
	assign active  = (h_count < `H_VISIBLE) && (v_count < `V_VISIBLE);
	assign h_pulse = (h_count >= `H_VISIBLE + `H_FRONT) &&
		(h_count < `H_VISIBLE + `H_FRONT + `H_SYNC); // 656 to 751
	assign v_pulse = (v_count >= `V_VISIBLE + `V_FRONT) &&
		(v_count < `V_VISIBLE + `V_FRONT + `V_SYNC); // lines 490 and 491

	always_ff @(posedge clk_50m or negedge rst_n) begin
		if (!rst_n) begin
			pix_en  <= 1'b0;
			h_count <= '0;
			v_count <= '0;
			hsync   <= 1'b1;
			vsync   <= 1'b1;
		end else begin
			pix_en <= ~pix_en; // 25 MHz tick
			if (pix_en) begin
				hsync <= ~h_pulse; // same stage as the renderer colour
				vsync <= ~v_pulse;
				if (h_last) begin
					h_count <= '0;
					v_count <= v_last ? '0 : v_count + 10'd1;
				end else begin
					h_count <= h_count + 10'd1;
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+common
common/grid_pkg.sv
common/video_pkg.sv
grid/grid_engine.sv
grid/grid_memory.sv
video/vga_sync.sv
video/grid_renderer.sv
verilog/battleship_top.sv
dv/battleship_tb.sv
